// ==== hw/eltwise_pkg.sv ====
package eltwise_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes of the datapath and the memories
  ////////////////////////////////////////////////////////////

  localparam int LANES = 4;
  localparam int LANE_W = 16;
  localparam int WORD_W = LANES * LANE_W;
  localparam int AWIDTH = 6;
  localparam int CNT_W = 6;

  // Read latency of the A and B memories in cycles
  localparam int MEM_LATENCY = 1;

  // Beats in flight between issue and the result register
  localparam int PIPE_DEPTH = MEM_LATENCY + 1;

  // Credits granted by the consumer after reset
  localparam int CREDITS_MAX = 4;
  localparam int CREDIT_W = $clog2(CREDITS_MAX + 1);

  ////////////////////////////////////////////////////////////
  // Operation codes and lane views
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MAX = 2'd2,
    OP_MIN = 2'd3
  } op_e;

  // Half precision layout, sign on top
  typedef struct packed {
    logic       sign;
    logic [4:0] exponent;
    logic [9:0] mantissa;
  } fp16_t;

  // Integer ops look at raw, compare ops look at fp
  typedef union packed {
    logic [LANE_W-1:0] raw;
    fp16_t             fp;
  } lane_u;

  ////////////////////////////////////////////////////////////
  // Port bundles
  ////////////////////////////////////////////////////////////

  // Preload write, sel picks the memory (0 for A, 1 for B)
  typedef struct packed {
    logic              valid;
    logic              sel;
    logic [AWIDTH-1:0] addr;
    logic [WORD_W-1:0] data;
  } mem_wr_t;

  typedef struct packed {
    logic              start;
    op_e               op;
    logic [AWIDTH-1:0] base_a;
    logic [AWIDTH-1:0] base_b;
    logic [CNT_W-1:0]  count;
    logic [LANES-1:0]  mask_a;
    logic [LANES-1:0]  mask_b;
  } cmd_t;

  typedef struct packed {
    logic                   valid;
    logic [CNT_W-1:0]       index;
    lane_u [LANES-1:0]      lanes;
  } result_t;

endpackage

// ==== hw/eltwise_bram.sv ====
`timescale 1ns/10ps

// Simple dual port memory of four-lane words
// One instance per operand bank, told apart by SEL
module eltwise_bram #(
  parameter logic SEL = 1'b0
) (
  input  logic                                clk,
  input  logic                                rst,
  input  eltwise_pkg::mem_wr_t                wr,
  input  logic [eltwise_pkg::AWIDTH-1:0]      rd_addr,
  output logic [eltwise_pkg::WORD_W-1:0]      rd_data
);

  logic [eltwise_pkg::WORD_W-1:0] mem [0:2**eltwise_pkg::AWIDTH-1];
  logic                           wr_en;

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  // Only the bank named by the write select takes the word
  // Writes are held off while the design sits in reset
  assign wr_en = wr.valid && (wr.sel == SEL) && !rst;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  // Data shows up one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== hw/eltwise_input_logic.sv ====
`timescale 1ns/10ps

// Address walker and lane qualifier in front of the lane unit
module eltwise_input_logic (
  input  logic                              clk,
  input  logic                              rst,
  input  eltwise_pkg::cmd_t                 cmd,
  input  logic                              load,
  input  logic                              issue,
  output logic                              last,
  output logic [eltwise_pkg::AWIDTH-1:0]    a_addr,
  output logic [eltwise_pkg::AWIDTH-1:0]    b_addr,
  input  logic [eltwise_pkg::WORD_W-1:0]    a_data,
  input  logic [eltwise_pkg::WORD_W-1:0]    b_data,
  output logic                              beat_valid,
  output logic [eltwise_pkg::CNT_W-1:0]     beat_index,
  output logic [eltwise_pkg::WORD_W-1:0]    a_masked,
  output logic [eltwise_pkg::WORD_W-1:0]    b_masked,
  output eltwise_pkg::op_e                  op
);

  localparam int L = eltwise_pkg::MEM_LATENCY;

  logic [eltwise_pkg::CNT_W-1:0] idx;
  logic [eltwise_pkg::CNT_W-1:0] count_q;
  logic [eltwise_pkg::LANES-1:0] mask_a_q;
  logic [eltwise_pkg::LANES-1:0] mask_b_q;
  logic [L-1:0]                  valid_pipe;
  logic [eltwise_pkg::CNT_W-1:0] idx_pipe [L];
  logic                          all_issued;

  ////////////////////////////////////////////////////////////
  // Command latch and address walk
  ////////////////////////////////////////////////////////////

  // Command fields are kept for the whole run, load overrides
  always_ff @(posedge clk) begin
    if (load) begin
      a_addr   <= cmd.base_a;
      b_addr   <= cmd.base_b;
      count_q  <= cmd.count;
      mask_a_q <= cmd.mask_a;
      mask_b_q <= cmd.mask_b;
      op       <= cmd.op;
    end else if (issue) begin
      a_addr <= a_addr + 1'b1;
      b_addr <= b_addr + 1'b1;
    end
  end

  // Beat counter and a flag that marks the run as fully issued
  always_ff @(posedge clk) begin
    if (rst) begin
      idx        <= '0;
      all_issued <= 1'b0;
    end else if (load) begin
      idx        <= '0;
      all_issued <= 1'b0;
    end else if (issue) begin
      idx <= idx + 1'b1;
      if (last) all_issued <= 1'b1;
    end
  end

  assign last = (idx == count_q - eltwise_pkg::CNT_W'(1));

  ////////////////////////////////////////////////////////////
  // Alignment with the memory read data
  ////////////////////////////////////////////////////////////

  // Issue and index ride along with the read for MEM_LATENCY cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe[0] <= issue;
      for (int i = 1; i < L; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    idx_pipe[0] <= idx;
    for (int i = 1; i < L; i++) begin
      idx_pipe[i] <= idx_pipe[i-1];
    end
  end

  assign beat_valid = valid_pipe[L-1];
  assign beat_index = idx_pipe[L-1];

  // A lane is forced to zero when its mask bit is clear or no beat is there
  always_comb begin
    for (int i = 0; i < eltwise_pkg::LANES; i++) begin
      a_masked[i*eltwise_pkg::LANE_W +: eltwise_pkg::LANE_W] =
        (beat_valid && mask_a_q[i]) ? a_data[i*eltwise_pkg::LANE_W +: eltwise_pkg::LANE_W] : '0;
      b_masked[i*eltwise_pkg::LANE_W +: eltwise_pkg::LANE_W] =
        (beat_valid && mask_b_q[i]) ? b_data[i*eltwise_pkg::LANE_W +: eltwise_pkg::LANE_W] : '0;
    end
  end

  // Once the final beat has gone out the controller must stay quiet until reload
  a_no_issue_past_last: assert property (
    @(posedge clk) disable iff (rst) issue |-> !all_issued
  );

endmodule

// ==== hw/eltwise_lane_alu.sv ====
`timescale 1ns/10ps

// Four lanes of element-wise arithmetic with one register stage
module eltwise_lane_alu (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              beat_valid,
  input  logic [eltwise_pkg::CNT_W-1:0]     beat_index,
  input  eltwise_pkg::op_e                  op,
  input  logic [eltwise_pkg::WORD_W-1:0]    a_masked,
  input  logic [eltwise_pkg::WORD_W-1:0]    b_masked,
  output eltwise_pkg::result_t              result
);

  eltwise_pkg::lane_u [eltwise_pkg::LANES-1:0] a_lanes;
  eltwise_pkg::lane_u [eltwise_pkg::LANES-1:0] b_lanes;
  eltwise_pkg::lane_u [eltwise_pkg::LANES-1:0] lanes_d;
  eltwise_pkg::lane_u [eltwise_pkg::LANES-1:0] lanes_q;
  logic [eltwise_pkg::CNT_W-1:0]               index_q;
  logic                                        valid_q;

  // True when a sits above b in sign and magnitude order
  // Opposite signs are settled by the sign alone, so -0 stays below +0
  function automatic logic fp_gt(eltwise_pkg::lane_u a, eltwise_pkg::lane_u b);
    logic [14:0] mag_a;
    logic [14:0] mag_b;
    mag_a = {a.fp.exponent, a.fp.mantissa};
    mag_b = {b.fp.exponent, b.fp.mantissa};
    if (a.fp.sign != b.fp.sign) return !a.fp.sign;
    // Among negatives the larger magnitude is the smaller number
    if (a.fp.sign) return mag_a < mag_b;
    return mag_a > mag_b;
  endfunction

  assign a_lanes = a_masked;
  assign b_lanes = b_masked;

  ////////////////////////////////////////////////////////////
  // Per lane operation
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < eltwise_pkg::LANES; i++) begin
      unique case (op)
        eltwise_pkg::OP_ADD: lanes_d[i].raw = a_lanes[i].raw + b_lanes[i].raw;
        eltwise_pkg::OP_SUB: lanes_d[i].raw = a_lanes[i].raw - b_lanes[i].raw;
        eltwise_pkg::OP_MAX: lanes_d[i] = fp_gt(a_lanes[i], b_lanes[i]) ? a_lanes[i] : b_lanes[i];
        default:             lanes_d[i] = fp_gt(a_lanes[i], b_lanes[i]) ? b_lanes[i] : a_lanes[i];
      endcase
    end
  end

  // Output register, only the valid bit is cleared by reset
  always_ff @(posedge clk) begin
    if (rst) valid_q <= 1'b0;
    else     valid_q <= beat_valid;
  end

  always_ff @(posedge clk) begin
    lanes_q <= lanes_d;
    index_q <= beat_index;
  end

  assign result = '{valid: valid_q, index: index_q, lanes: lanes_q};

endmodule

// ==== hw/eltwise_credit_counter.sv ====
`timescale 1ns/10ps

// Credits the result stream may still spend
module eltwise_credit_counter (
  input  logic clk,
  input  logic rst,
  input  logic spend,
  input  logic credit_return,
  output logic has_credit
);

  logic [eltwise_pkg::CREDIT_W-1:0] count;

  // A spend and a return in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= eltwise_pkg::CREDIT_W'(eltwise_pkg::CREDITS_MAX);
    end else if (spend && !credit_return) begin
      count <= count - 1'b1;
    end else if (credit_return && !spend) begin
      count <= count + 1'b1;
    end
  end

  assign has_credit = (count != '0);

  a_no_spend_empty: assert property (@(posedge clk) disable iff (rst) spend |-> count != '0);

  // The consumer can only hand back what it was given
  a_no_return_full: assert property (
    @(posedge clk) disable iff (rst)
    credit_return |-> count != eltwise_pkg::CREDIT_W'(eltwise_pkg::CREDITS_MAX)
  );

endmodule

// ==== hw/eltwise_ctrl_fsm.sv ====
`timescale 1ns/10ps

// Run control that accepts a command, issues against credits, drains and reports done
module eltwise_ctrl_fsm (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic has_credit,
  input  logic last,
  output logic load,
  output logic issue,
  output logic busy,
  output logic done
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } state_e;

  state_e     state;
  logic [1:0] drain_cnt;

  // Start is only seen in IDLE, so a start while busy has no effect
  assign load  = (state == IDLE) && start;
  assign issue = (state == RUN) && has_credit;
  assign busy  = (state != IDLE);
  // Final drain cycle is the one right after the last result
  assign done  = (state == DRAIN) && (drain_cnt == 2'(eltwise_pkg::PIPE_DEPTH));

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      drain_cnt <= '0;
    end else begin
      unique case (state)
        IDLE: if (load) state <= RUN;
        RUN: begin
          drain_cnt <= '0;
          if (issue && last) state <= DRAIN;
        end
        default: begin
          // Beats still travel through memory and lane stages here
          drain_cnt <= drain_cnt + 1'b1;
          if (done) state <= IDLE;
        end
      endcase
    end
  end

endmodule

// ==== hw/eltwise_top.sv ====
`timescale 1ns/10ps

// Element-wise vector unit, two operand banks feeding four lanes
module eltwise_top (
  input  logic                    clk,
  input  logic                    rst,
  input  eltwise_pkg::mem_wr_t    mem_wr,
  input  eltwise_pkg::cmd_t       cmd,
  input  logic                    credit_return,
  output eltwise_pkg::result_t    result,
  output logic                    busy,
  output logic                    done
);

  logic [eltwise_pkg::AWIDTH-1:0] a_addr;
  logic [eltwise_pkg::AWIDTH-1:0] b_addr;
  logic [eltwise_pkg::WORD_W-1:0] a_data;
  logic [eltwise_pkg::WORD_W-1:0] b_data;
  logic [eltwise_pkg::WORD_W-1:0] a_masked;
  logic [eltwise_pkg::WORD_W-1:0] b_masked;
  logic [eltwise_pkg::CNT_W-1:0]  beat_index;
  eltwise_pkg::op_e               op;
  logic                           load;
  logic                           issue;
  logic                           last;
  logic                           has_credit;
  logic                           beat_valid;

  ////////////////////////////////////////////////////////////
  // Operand memories
  ////////////////////////////////////////////////////////////

  eltwise_bram #(.SEL(1'b0)) bram_a_i (
    .clk(clk), .rst(rst), .wr(mem_wr), .rd_addr(a_addr), .rd_data(a_data)
  );

  eltwise_bram #(.SEL(1'b1)) bram_b_i (
    .clk(clk), .rst(rst), .wr(mem_wr), .rd_addr(b_addr), .rd_data(b_data)
  );

  ////////////////////////////////////////////////////////////
  // Datapath and control
  ////////////////////////////////////////////////////////////

  eltwise_input_logic input_logic_i (
    .clk(clk), .rst(rst), .cmd(cmd), .load(load), .issue(issue), .last(last),
    .a_addr(a_addr), .b_addr(b_addr), .a_data(a_data), .b_data(b_data),
    .beat_valid(beat_valid), .beat_index(beat_index),
    .a_masked(a_masked), .b_masked(b_masked), .op(op)
  );

  eltwise_lane_alu lane_alu_i (
    .clk(clk), .rst(rst), .beat_valid(beat_valid), .beat_index(beat_index), .op(op),
    .a_masked(a_masked), .b_masked(b_masked), .result(result)
  );

  // Credits are spent at issue since the stream has no ready
  eltwise_credit_counter credit_counter_i (
    .clk(clk), .rst(rst), .spend(issue), .credit_return(credit_return),
    .has_credit(has_credit)
  );

  eltwise_ctrl_fsm ctrl_fsm_i (
    .clk(clk), .rst(rst), .start(cmd.start), .has_credit(has_credit), .last(last),
    .load(load), .issue(issue), .busy(busy), .done(done)
  );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps

// Free running 10 ns clock and a reset held for the first 8 rising edges
module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
  end

  always #5 clk = ~clk;

endmodule

// ==== test/eltwise_checker.sv ====
`timescale 1ns/10ps

// Watches the result stream and compares every beat with a model built from the memory mirror
module eltwise_checker (
  input logic                 clk,
  input logic                 rst,
  input eltwise_pkg::cmd_t    cmd,
  input logic                 credit_return,
  input eltwise_pkg::result_t result,
  input logic                 busy,
  input logic                 done
);

  int                value_errors = 0;
  int                protocol_errors = 0;
  int                results_seen = 0;
  int                outstanding = 0;
  int                tick = 0;
  int                last_result = 0;
  logic              active = 1'b0;
  eltwise_pkg::cmd_t run_cmd;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Maps a half precision value onto a signed key whose order is the value order
  // Negative keys start at -1 so that -0 lands just below +0
  function automatic int order_key(logic [15:0] v);
    if (v[15]) return -int'(v[14:0]) - 1;
    return int'(v[14:0]);
  endfunction

  function automatic logic [15:0] expected_lane(eltwise_pkg::op_e op, logic [15:0] a,
                                                logic [15:0] b);
    case (op)
      eltwise_pkg::OP_ADD: return a + b;
      eltwise_pkg::OP_SUB: return a - b;
      eltwise_pkg::OP_MAX: return (order_key(a) >= order_key(b)) ? a : b;
      default:             return (order_key(a) <= order_key(b)) ? a : b;
    endcase
  endfunction

  // Operands come from base plus beat index, wrapping at the top of the memory
  function automatic logic [eltwise_pkg::WORD_W-1:0] expected_word(int index);
    logic [eltwise_pkg::AWIDTH-1:0] addr_a;
    logic [eltwise_pkg::AWIDTH-1:0] addr_b;
    logic [eltwise_pkg::WORD_W-1:0] wa;
    logic [eltwise_pkg::WORD_W-1:0] wb;
    logic [eltwise_pkg::WORD_W-1:0] w;
    logic [15:0]                    la;
    logic [15:0]                    lb;
    addr_a = run_cmd.base_a + eltwise_pkg::AWIDTH'(index);
    addr_b = run_cmd.base_b + eltwise_pkg::AWIDTH'(index);
    wa = eltwise_tb.mirror_a[addr_a];
    wb = eltwise_tb.mirror_b[addr_b];
    for (int i = 0; i < eltwise_pkg::LANES; i++) begin
      la = run_cmd.mask_a[i] ? wa[i*eltwise_pkg::LANE_W +: eltwise_pkg::LANE_W] : 16'd0;
      lb = run_cmd.mask_b[i] ? wb[i*eltwise_pkg::LANE_W +: eltwise_pkg::LANE_W] : 16'd0;
      w[i*eltwise_pkg::LANE_W +: eltwise_pkg::LANE_W] = expected_lane(run_cmd.op, la, lb);
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stream monitor
  ////////////////////////////////////////////////////////////

  task automatic check_result();
    logic [eltwise_pkg::WORD_W-1:0] exp_w;
    logic [eltwise_pkg::WORD_W-1:0] act_w;
    if (!active || results_seen >= int'(run_cmd.count)) begin
      $display("Unexpected extra result with index %0d in row %s", result.index,
               eltwise_tb.cur_name);
      protocol_errors++;
    end else begin
      if (result.index != eltwise_pkg::CNT_W'(results_seen)) begin
        $display("ERROR %s index: expected %0d, actual %0d", eltwise_tb.cur_name,
                 results_seen, result.index);
        value_errors++;
      end
      exp_w = expected_word(results_seen);
      act_w = result.lanes;
      if (act_w !== exp_w) begin
        $display("ERROR %s beat %0d: expected %h, actual %h", eltwise_tb.cur_name,
                 results_seen, exp_w, act_w);
        value_errors++;
      end
      results_seen++;
    end
  endtask

  // Sampling on the falling edge keeps clear of the rising edge updates
  always @(negedge clk) begin
    tick++;
    if (!rst) begin
      // Acceptance happens on the next rising edge while busy is still low
      if (cmd.start && !busy) begin
        active       = 1'b1;
        run_cmd      = cmd;
        results_seen = 0;
      end
      if (result.valid) begin
        outstanding++;
        // Credits that come straight back keep the pool full, so beats follow every cycle
        if (active && results_seen > 0 && results_seen < int'(run_cmd.count) &&
            eltwise_tb.credit_delay == 0 && tick != last_result + 1) begin
          $display("Row %s has a gap between results although credits return at once",
                   eltwise_tb.cur_name);
          protocol_errors++;
        end
        check_result();
        last_result = tick;
      end
      if (credit_return) outstanding--;
      // Results not yet paid back can never exceed the credit pool
      if (outstanding > eltwise_pkg::CREDITS_MAX) begin
        $display("More than %0d results are waiting for a credit", eltwise_pkg::CREDITS_MAX);
        protocol_errors++;
      end
      if (outstanding < 0) begin
        $display("A credit was returned for a result that never arrived");
        protocol_errors++;
      end
      if (done) begin
        if (!active) begin
          $display("Done pulse seen with no command running");
          protocol_errors++;
        end else if (results_seen != int'(run_cmd.count)) begin
          $display("Row %s ended after %0d results while %0d were expected",
                   eltwise_tb.cur_name, results_seen, run_cmd.count);
          protocol_errors++;
        end else if (tick != last_result + 1) begin
          $display("Row %s raised done %0d cycles after its last result",
                   eltwise_tb.cur_name, tick - last_result);
          protocol_errors++;
        end
        active = 1'b0;
      end
    end
  end

endmodule

// ==== test/eltwise_tb.sv ====
`timescale 1ns/10ps

module eltwise_tb;

  typedef struct {
    string                          name;
    eltwise_pkg::op_e               op;
    logic [eltwise_pkg::AWIDTH-1:0] base_a;
    logic [eltwise_pkg::AWIDTH-1:0] base_b;
    logic [eltwise_pkg::CNT_W-1:0]  count;
    logic [eltwise_pkg::LANES-1:0]  mask_a;
    logic [eltwise_pkg::LANES-1:0]  mask_b;
    int                             credit_delay;
    logic                           start_while_busy;
  } row_t;

  logic                           clk;
  logic                           rst;
  eltwise_pkg::mem_wr_t           mem_wr;
  eltwise_pkg::cmd_t              cmd;
  logic                           credit_return;
  eltwise_pkg::result_t           result;
  logic                           busy;
  logic                           done;

  // Mirror of both memories that the checker reads
  logic [eltwise_pkg::WORD_W-1:0] mirror_a [2**eltwise_pkg::AWIDTH];
  logic [eltwise_pkg::WORD_W-1:0] mirror_b [2**eltwise_pkg::AWIDTH];
  logic [31:0]                    rng_state = 32'd79995;
  logic [eltwise_pkg::WORD_W-1:0] special [8];
  row_t                           rows [$];
  int                             due_q [$];
  string                          cur_name = "reset";
  int                             credit_delay = 0;
  int                             cycle = 0;
  int                             limit = 0;
  int                             tb_errors = 0;
  int                             total;

  tb_clock clock_i (.clk(clk), .rst(rst));

  eltwise_top eltwise_top_i (
    .clk(clk), .rst(rst), .mem_wr(mem_wr), .cmd(cmd), .credit_return(credit_return),
    .result(result), .busy(busy), .done(done)
  );

  eltwise_checker checker_i (
    .clk(clk), .rst(rst), .cmd(cmd), .credit_return(credit_return), .result(result),
    .busy(busy), .done(done)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // xorshift32 step
  function logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic add_row(string name, eltwise_pkg::op_e op,
                         logic [eltwise_pkg::AWIDTH-1:0] base_a,
                         logic [eltwise_pkg::AWIDTH-1:0] base_b,
                         logic [eltwise_pkg::CNT_W-1:0] count,
                         logic [eltwise_pkg::LANES-1:0] mask_a,
                         logic [eltwise_pkg::LANES-1:0] mask_b,
                         int delay, logic busy_start);
    rows.push_back('{name, op, base_a, base_b, count, mask_a, mask_b, delay, busy_start});
  endtask

  task automatic write_word(logic sel, logic [eltwise_pkg::AWIDTH-1:0] addr,
                            logic [eltwise_pkg::WORD_W-1:0] data);
    mem_wr = '{valid: 1'b1, sel: sel, addr: addr, data: data};
    if (sel) mirror_b[addr] = data;
    else     mirror_a[addr] = data;
    @(posedge clk);
    #1;
  endtask

  // Random fill of both banks followed by signed corner cases at words 56 to 63
  task automatic preload();
    logic [31:0] hi;
    logic [31:0] lo;
    for (int s = 0; s < 2; s++) begin
      for (int a = 0; a < 2**eltwise_pkg::AWIDTH; a++) begin
        hi = next_random();
        lo = next_random();
        write_word(1'(s), eltwise_pkg::AWIDTH'(a), {hi, lo});
      end
    end
    // Lanes run 3 down to 0 and A takes words 56 to 59 while B takes 60 to 63
    special[0] = 64'hC000_BC00_3C00_8000;
    special[1] = 64'h8001_0001_C500_4500;
    special[2] = 64'h8000_0000_7BFF_FBFF;
    special[3] = 64'hD000_3555_C100_C200;
    special[4] = 64'hBE00_3C00_BC00_0000;
    special[5] = 64'h0001_8001_4500_C500;
    special[6] = 64'h0000_8000_7BFE_FBFE;
    special[7] = 64'hCFFF_3555_C200_C100;
    for (int i = 0; i < 8; i++) begin
      write_word(i >= 4, eltwise_pkg::AWIDTH'(56 + i), special[i]);
    end
    mem_wr = '0;
  endtask

  task automatic apply_row(row_t r);
    // Every row starts with the whole credit pool back at the DUT
    while (due_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    cur_name     = r.name;
    credit_delay = r.credit_delay;
    cmd = '{start: 1'b1, op: r.op, base_a: r.base_a, base_b: r.base_b, count: r.count,
            mask_a: r.mask_a, mask_b: r.mask_b};
    @(posedge clk);
    #1;
    cmd.start = 1'b0;
    // A second start in the middle of the run must be ignored
    if (r.start_while_busy) begin
      repeat (2) @(posedge clk);
      #1;
      if (!busy) begin
        $display("Row %s was not busy when the extra start was given", r.name);
        tb_errors++;
      end
      cmd.start = 1'b1;
      @(posedge clk);
      #1;
      cmd.start = 1'b0;
    end
    while (!done) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    if (busy) begin
      $display("Row %s left busy high after its done pulse", r.name);
      tb_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Credit return and cycle count
  ////////////////////////////////////////////////////////////

  always @(posedge clk) cycle <= cycle + 1;

  // Each result books a return credit_delay cycles later with at most one pulse per cycle
  always @(posedge clk) begin
    #1;
    if (rst) begin
      credit_return = 1'b0;
    end else begin
      if (result.valid) due_q.push_back(cycle + credit_delay);
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        credit_return = 1'b1;
        void'(due_q.pop_front());
      end else begin
        credit_return = 1'b0;
      end
    end
  end

  initial begin
    wait (limit > 0);
    while (cycle < limit) @(posedge clk);
    $display("Timeout after %0d cycles, the run never reached its end", cycle);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    mem_wr        = '0;
    cmd           = '0;
    credit_return = 1'b0;
    add_row("add_full", eltwise_pkg::OP_ADD, 6'd0, 6'd8, 6'd8, 4'hF, 4'hF, 0, 1'b0);
    add_row("sub_full", eltwise_pkg::OP_SUB, 6'd16, 6'd3, 6'd10, 4'hF, 4'hF, 0, 1'b0);
    add_row("sub_neg_b", eltwise_pkg::OP_SUB, 6'd5, 6'd20, 6'd4, 4'h0, 4'hF, 0, 1'b0);
    add_row("add_part", eltwise_pkg::OP_ADD, 6'd30, 6'd40, 6'd6, 4'h5, 4'hC, 1, 1'b0);
    add_row("max_corner", eltwise_pkg::OP_MAX, 6'd56, 6'd60, 6'd4, 4'hF, 4'hF, 0, 1'b0);
    add_row("min_corner", eltwise_pkg::OP_MIN, 6'd56, 6'd60, 6'd4, 4'hF, 4'hF, 2, 1'b0);
    add_row("max_rand", eltwise_pkg::OP_MAX, 6'd10, 6'd33, 6'd12, 4'hF, 4'hF, 0, 1'b0);
    add_row("min_part", eltwise_pkg::OP_MIN, 6'd44, 6'd2, 6'd7, 4'hB, 4'hF, 3, 1'b0);
    add_row("add_slow", eltwise_pkg::OP_ADD, 6'd0, 6'd32, 6'd10, 4'hF, 4'hF, 12, 1'b0);
    add_row("sub_busy", eltwise_pkg::OP_SUB, 6'd48, 6'd12, 6'd9, 4'hF, 4'h6, 5, 1'b1);
    add_row("add_wrap", eltwise_pkg::OP_ADD, 6'd62, 6'd61, 6'd4, 4'hF, 4'hF, 0, 1'b0);
    // Cycle budget grows with beats and credit delay of every row
    total = 150;
    foreach (rows[i]) total += int'(rows[i].count) * (rows[i].credit_delay + 4) + 20;
    limit = total;
    @(negedge rst);
    @(posedge clk);
    #1;
    preload();
    foreach (rows[i]) apply_row(rows[i]);
    while (due_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (2) @(posedge clk);
    #1;
    total = checker_i.value_errors + checker_i.protocol_errors + tb_errors;
    $display("Errors: value %0d, protocol %0d, testbench %0d", checker_i.value_errors,
             checker_i.protocol_errors, tb_errors);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
hw/eltwise_pkg.sv
hw/eltwise_bram.sv
hw/eltwise_input_logic.sv
hw/eltwise_lane_alu.sv
hw/eltwise_credit_counter.sv
hw/eltwise_ctrl_fsm.sv
hw/eltwise_top.sv
test/tb_clock.sv
test/eltwise_checker.sv
test/eltwise_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the eltwise testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module eltwise_tb -o eltwise_sim

# The log decides pass or fail, so a failing run must not stop the script here
./obj_dir/eltwise_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^Test OK$" sim.log
